// ==== source/pmp_pkg.sv ====
// PMP package: address widths, mode and access encodings, entry config, write, region, fault types
package pmp_pkg;

  // --------------------
  // Widths
  // --------------------

  // Request byte address and entry word address share one width
  localparam int unsigned PMP_ADDR_W = 32;
  // Word address shifted up by two bits becomes a 34-bit byte address
  localparam int unsigned PMP_EXT_W  = PMP_ADDR_W + 2;

  typedef logic [PMP_ADDR_W-1:0] pmp_addr_t;
  typedef logic [PMP_EXT_W-1:0]  pmp_ext_addr_t;

  // --------------------
  // Encodings
  // --------------------

  // Address matching mode, same values as the A field of pmpcfg
  typedef logic [1:0] pmp_mode_t;
  localparam pmp_mode_t PMP_OFF   = 2'd0;
  localparam pmp_mode_t PMP_TOR   = 2'd1;
  localparam pmp_mode_t PMP_NA4   = 2'd2;
  localparam pmp_mode_t PMP_NAPOT = 2'd3;

  // Access kind carried with each channel request
  typedef logic [1:0] pmp_acc_t;
  localparam pmp_acc_t PMP_READ  = 2'd0;
  localparam pmp_acc_t PMP_WRITE = 2'd1;
  localparam pmp_acc_t PMP_EXEC  = 2'd2;

  // --------------------
  // Structures
  // --------------------

  // Entry configuration, lock on top and R in bit 0
  typedef struct packed {
    logic      lock;
    pmp_mode_t mode;
    logic      execute;
    logic      write;
    logic      read;
  } pmp_cfg_t;

  // One write on the configuration port
  typedef struct packed {
    logic [3:0] index;
    logic       sel_addr;  // set: address register, clear: config
    pmp_addr_t  data;
  } pmp_cfg_wr_t;

  // Decoded entry, shared by every channel checker
  typedef struct packed {
    pmp_ext_addr_t start;
    pmp_ext_addr_t top;
    pmp_ext_addr_t mask;
    pmp_cfg_t      cfg;
  } pmp_region_t;

  typedef struct packed {
    pmp_addr_t addr;
    pmp_acc_t  acc;
  } pmp_chan_req_t;

  typedef struct packed {
    logic [3:0] chan;
    pmp_addr_t  addr;
    pmp_acc_t   acc;
  } pmp_fault_t;

  // Checker handshake FSM
  typedef enum logic {
    HS_IDLE,
    HS_ACK
  } pmp_hs_state_e;

endpackage

// ==== source/pmp_cfg_regs.sv ====
// PMP entry bank: configuration and address registers behind a four-phase write port
`timescale 1ns/100ps

module pmp_cfg_regs #(
  parameter int unsigned NUM_ENTRIES = 8
) (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  // Four-phase write port
  input  logic                  cfg_req_i,
  input  pmp_pkg::pmp_cfg_wr_t  cfg_wr_i,
  output logic                  cfg_ack_o,
  // Entry contents towards the region decoder
  output pmp_pkg::pmp_cfg_t     cfg_o  [NUM_ENTRIES],
  output pmp_pkg::pmp_addr_t    addr_o [NUM_ENTRIES]
);

  import pmp_pkg::*;

  // Write strobe, high only on the edge that raises ack
  logic wr_en;

  // --------------------
  // Handshake
  // --------------------

  // New request seen while ack still low
  assign wr_en = cfg_req_i && !cfg_ack_o;

  // Single ack flop
  // rises with the write, falls once req is seen low
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cfg_ack_o <= 1'b0;
    end else if (wr_en) begin
      cfg_ack_o <= 1'b1;
    end else if (!cfg_req_i) begin
      cfg_ack_o <= 1'b0;
    end
  end

  // --------------------
  // Entry registers
  // --------------------

  // Index at or above NUM_ENTRIES hits no entry, so it is acked and dropped
  for (genvar e = 0; e < NUM_ENTRIES; e++) begin : g_entry
    logic hit;

    assign hit = wr_en && (cfg_wr_i.index == 4'(e));

    // Config comes up zero, i.e. OFF and unlocked
    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        cfg_o[e] <= '0;
      end else if (hit && !cfg_wr_i.sel_addr) begin
        // Low bits of data carry the config fields
        cfg_o[e] <= pmp_cfg_t'(cfg_wr_i.data[$bits(pmp_cfg_t)-1:0]);
      end
    end

    // Word address of the entry
    always_ff @(posedge clk_i) begin
      if (hit && cfg_wr_i.sel_addr) begin
        addr_o[e] <= cfg_wr_i.data;
      end
    end
  end

endmodule

// ==== source/pmp_region_decode.sv ====
// PMP region decoder: start, top and NAPOT mask for each entry
`timescale 1ns/100ps

module pmp_region_decode #(
  parameter int unsigned NUM_ENTRIES = 8,
  parameter int unsigned GRANULARITY = 0
) (
  input  pmp_pkg::pmp_cfg_t    cfg_i    [NUM_ENTRIES],
  input  pmp_pkg::pmp_addr_t   addr_i   [NUM_ENTRIES],
  output pmp_pkg::pmp_region_t region_o [NUM_ENTRIES]
);

  import pmp_pkg::*;

  // Lowest compared bit of the byte address
  localparam int unsigned LO_BIT = GRANULARITY + 2;
  // Clears the bits inside one granule
  localparam pmp_ext_addr_t GRAN_KEEP = ~((pmp_ext_addr_t'(1) << LO_BIT) - pmp_ext_addr_t'(1));
  // Lowest address bit that takes part in the trailing-ones run
  localparam int unsigned RUN_BASE = (GRANULARITY == 0) ? 2 : GRANULARITY + 1;

  // Entry word addresses as byte addresses
  pmp_ext_addr_t ext_addr [NUM_ENTRIES];

  for (genvar e = 0; e < NUM_ENTRIES; e++) begin : g_entry
    pmp_ext_addr_t base;
    pmp_ext_addr_t raw_mask;
    logic          napot;

    assign ext_addr[e] = {addr_i[e], 2'b00};
    assign napot       = (cfg_i[e].mode == PMP_NAPOT);

    // --------------------
    // TOR bounds
    // --------------------

    // TOR starts at the previous entry, entry 0 starts at zero
    if (e == 0) begin : g_first
      assign base = (cfg_i[e].mode == PMP_TOR) ? '0 : ext_addr[e];
    end else begin : g_rest
      assign base = (cfg_i[e].mode == PMP_TOR) ? ext_addr[e-1] : ext_addr[e];
    end

    // NAPOT mask, bit set means compare
    // a bit is compared only above the run of trailing ones, e.g.
    // addr yyyy_0111 gives mask 1111_0000
    always_comb begin : p_mask
      logic run;
      run = 1'b1;
      for (int b = 0; b < PMP_EXT_W; b++) begin
        if (b > RUN_BASE) begin
          run = run & ext_addr[e][b-1];
        end
        // Bit 2 always masked for NAPOT, NA4 keeps every bit
        raw_mask[b] = !napot || !run;
      end
    end

    // Granule bits never compared, bounds aligned to the granule
    assign region_o[e].start = base & GRAN_KEEP;
    assign region_o[e].top   = ext_addr[e] & GRAN_KEEP;
    assign region_o[e].mask  = raw_mask & GRAN_KEEP;
    assign region_o[e].cfg   = cfg_i[e];
  end

endmodule

// ==== source/pmp_chan_check.sv ====
// PMP channel checker: region match, priority select and four-phase request handshake
`timescale 1ns/100ps

module pmp_chan_check #(
  parameter int unsigned NUM_ENTRIES = 8,
  parameter int unsigned CHAN_ID     = 0
) (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  // Four-phase request port
  input  logic                   chan_req_i,
  input  pmp_pkg::pmp_chan_req_t chan_i,
  output logic                   chan_ack_o,
  output logic                   chan_err_o,
  // Decoded regions, shared by all channels
  input  pmp_pkg::pmp_region_t   region_i [NUM_ENTRIES],
  // One-cycle fault pulse towards the log
  output logic                   fault_vld_o,
  output pmp_pkg::pmp_fault_t    fault_o
);

  import pmp_pkg::*;

  pmp_hs_state_e            state_q;
  pmp_ext_addr_t            req_addr;
  logic [NUM_ENTRIES-1:0]   match_eq;
  logic [NUM_ENTRIES-1:0]   match_ge;
  logic [NUM_ENTRIES-1:0]   match_lt;
  logic [NUM_ENTRIES-1:0]   match;
  logic [NUM_ENTRIES-1:0]   allow;
  logic                     err_d;
  logic                     take;

  // --------------------
  // Region matching
  // --------------------

  // Request byte address widened to 34 bits
  assign req_addr = {2'b00, chan_i.addr};

  for (genvar r = 0; r < NUM_ENTRIES; r++) begin : g_region
    logic perm;

    assign match_eq[r] = ((req_addr ^ region_i[r].start) & region_i[r].mask) == '0;
    assign match_ge[r] = req_addr >= region_i[r].start;
    assign match_lt[r] = req_addr < region_i[r].top;

    // Mode picks the comparison, OFF never matches
    always_comb begin
      case (region_i[r].cfg.mode)
        PMP_TOR:   match[r] = match_ge[r] && match_lt[r];
        PMP_NA4:   match[r] = match_eq[r];
        PMP_NAPOT: match[r] = match_eq[r];
        default:   match[r] = 1'b0;
      endcase
    end

    // Permission bit for this access kind
    always_comb begin
      case (chan_i.acc)
        PMP_READ:  perm = region_i[r].cfg.read;
        PMP_WRITE: perm = region_i[r].cfg.write;
        PMP_EXEC:  perm = region_i[r].cfg.execute;
        default:   perm = 1'b0;
      endcase
    end

    // Unlocked entry lets machine mode through
    assign allow[r] = !region_i[r].cfg.lock || perm;
  end

  // Lowest-numbered match decides, no match means allowed
  always_comb begin : p_prio
    logic found;
    found = 1'b0;
    err_d = 1'b0;
    for (int r = 0; r < NUM_ENTRIES; r++) begin
      if (!found && match[r]) begin
        found = 1'b1;
        err_d = !allow[r];
      end
    end
  end

  // --------------------
  // Handshake FSM
  // --------------------

  // Request sampled on the edge that leaves idle
  assign take       = (state_q == HS_IDLE) && chan_req_i;
  assign chan_ack_o = (state_q == HS_ACK);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q     <= HS_IDLE;
      chan_err_o  <= 1'b0;
      fault_vld_o <= 1'b0;
    end else begin
      fault_vld_o <= take && err_d;
      if (take) begin
        state_q    <= HS_ACK;
        chan_err_o <= err_d;
      end else if (state_q == HS_ACK && !chan_req_i) begin
        state_q <= HS_IDLE;
      end
    end
  end

  // Fault record, only meaningful with the pulse
  always_ff @(posedge clk_i) begin
    if (take) begin
      fault_o.chan <= 4'(CHAN_ID);
      fault_o.addr <= chan_i.addr;
      fault_o.acc  <= chan_i.acc;
    end
  end

endmodule

// ==== source/pmp_fault_log.sv ====
// PMP fault log: sticky first-fault record with lowest-channel priority and clear
`timescale 1ns/100ps

module pmp_fault_log #(
  parameter int unsigned NUM_CHANNELS = 3
) (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  // Fault pulses from the channel checkers
  input  logic [NUM_CHANNELS-1:0]   fault_vld_i,
  input  pmp_pkg::pmp_fault_t       fault_i [NUM_CHANNELS],
  // Software side
  input  logic                      fault_clr_i,
  output logic                      fault_vld_o,
  output pmp_pkg::pmp_fault_t       fault_o
);

  import pmp_pkg::*;

  pmp_fault_t pick;
  logic       capture;

  // --------------------
  // Channel select
  // --------------------

  // Fixed priority, lowest channel wins
  always_comb begin
    pick = fault_i[0];
    for (int c = NUM_CHANNELS - 1; c >= 0; c--) begin
      if (fault_vld_i[c]) begin
        pick = fault_i[c];
      end
    end
  end

  // Only an empty log takes a fault, clear has the upper hand
  assign capture = !fault_vld_o && (|fault_vld_i) && !fault_clr_i;

  // --------------------
  // Record
  // --------------------

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      fault_vld_o <= 1'b0;
    end else if (fault_clr_i) begin
      fault_vld_o <= 1'b0;
    end else if (capture) begin
      fault_vld_o <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (capture) begin
      fault_o <= pick;
    end
  end

endmodule

// ==== source/pmp_top.sv ====
// PMP top level: entry bank, region decoder, channel checker array and fault log
`timescale 1ns/100ps

module pmp_top #(
  parameter int unsigned NUM_ENTRIES  = 8,
  parameter int unsigned NUM_CHANNELS = 3,
  parameter int unsigned GRANULARITY  = 0
) (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  // Configuration port
  input  logic                      cfg_req_i,
  input  pmp_pkg::pmp_cfg_wr_t      cfg_wr_i,
  output logic                      cfg_ack_o,
  // Access channels
  input  logic [NUM_CHANNELS-1:0]   chan_req_i,
  input  pmp_pkg::pmp_chan_req_t    chan_i [NUM_CHANNELS],
  output logic [NUM_CHANNELS-1:0]   chan_ack_o,
  output logic [NUM_CHANNELS-1:0]   chan_err_o,
  // Fault log
  input  logic                      fault_clr_i,
  output logic                      fault_vld_o,
  output pmp_pkg::pmp_fault_t       fault_o
);

  import pmp_pkg::*;

  pmp_cfg_t                  cfg      [NUM_ENTRIES];
  pmp_addr_t                 addr     [NUM_ENTRIES];
  pmp_region_t               region   [NUM_ENTRIES];
  logic [NUM_CHANNELS-1:0]   fault_vld;
  pmp_fault_t                fault    [NUM_CHANNELS];

  // Entry bank
  pmp_cfg_regs #(
    .NUM_ENTRIES (NUM_ENTRIES)
  ) u_cfg_regs (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .cfg_req_i (cfg_req_i),
    .cfg_wr_i  (cfg_wr_i),
    .cfg_ack_o (cfg_ack_o),
    .cfg_o     (cfg),
    .addr_o    (addr)
  );

  // Decoded once, read by every channel
  pmp_region_decode #(
    .NUM_ENTRIES (NUM_ENTRIES),
    .GRANULARITY (GRANULARITY)
  ) u_region_decode (
    .cfg_i    (cfg),
    .addr_i   (addr),
    .region_o (region)
  );

  // --------------------
  // Checker array
  // --------------------

  for (genvar c = 0; c < NUM_CHANNELS; c++) begin : g_chan
    pmp_chan_check #(
      .NUM_ENTRIES (NUM_ENTRIES),
      .CHAN_ID     (c)
    ) u_chan_check (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .chan_req_i  (chan_req_i[c]),
      .chan_i      (chan_i[c]),
      .chan_ack_o  (chan_ack_o[c]),
      .chan_err_o  (chan_err_o[c]),
      .region_i    (region),
      .fault_vld_o (fault_vld[c]),
      .fault_o     (fault[c])
    );
  end

  // First denied access, held for software
  pmp_fault_log #(
    .NUM_CHANNELS (NUM_CHANNELS)
  ) u_fault_log (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .fault_vld_i (fault_vld),
    .fault_i     (fault),
    .fault_clr_i (fault_clr_i),
    .fault_vld_o (fault_vld_o),
    .fault_o     (fault_o)
  );

endmodule

// ==== sim/pmp_props.sv ====
// Handshake assertions for the PMP channel checker and the bind onto every checker
`timescale 1ns/100ps

module pmp_props (
  input logic clk_i,
  input logic arst_n_i,
  input logic chan_req_i,
  input logic chan_ack_o,
  input logic chan_err_o
);

  // Failed assertions, summed by the testbench
  int unsigned fail_cnt = 0;

  // --------------------
  // Handshake
  // --------------------

  // Ack only follows a sampled request
  a_ack_rise: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $rose(chan_ack_o) |-> $past(chan_req_i))
    else begin
      $error("checker ack rose without a request");
      fail_cnt++;
    end

  // Ack stays up while the master holds req
  a_ack_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    chan_ack_o && chan_req_i |=> chan_ack_o)
    else begin
      $error("checker ack dropped while req was still high");
      fail_cnt++;
    end

  // Result frozen for the whole ack phase
  a_err_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    chan_ack_o |=> !chan_ack_o || $stable(chan_err_o))
    else begin
      $error("checker error bit changed while ack was high");
      fail_cnt++;
    end

  a_rst_ack: assert property (@(posedge clk_i) !arst_n_i |-> !chan_ack_o)
    else begin
      $error("checker ack high during reset");
      fail_cnt++;
    end

endmodule

bind pmp_chan_check pmp_props u_props (
  .clk_i      (clk_i),
  .arst_n_i   (arst_n_i),
  .chan_req_i (chan_req_i),
  .chan_ack_o (chan_ack_o),
  .chan_err_o (chan_err_o)
);

// ==== sim/pmp_tb.sv ====
// Testbench for the PMP top level: cases file, config and channel handshakes, fault log checks
`timescale 1ns/100ps

module pmp_tb;

  import pmp_pkg::*;

  localparam int unsigned NUM_CH    = 3;
  localparam int unsigned MAX_CASES = 64;
  localparam int unsigned MAX_FLDS  = 9;

  logic              clk;
  logic              arst_n;
  logic              cfg_req;
  pmp_cfg_wr_t       cfg_wr;
  logic              cfg_ack;
  logic [NUM_CH-1:0] chan_req;
  pmp_chan_req_t     chan [NUM_CH];
  logic [NUM_CH-1:0] chan_ack;
  logic [NUM_CH-1:0] chan_err;
  logic              fault_clr;
  logic              fault_vld;
  pmp_fault_t        fault;

  // Parsed cases with one kind letter and up to nine fields each
  byte               kind [MAX_CASES];
  logic [31:0]       fld  [MAX_CASES][MAX_FLDS];
  int unsigned       num_cases;
  int unsigned       errors;
  int unsigned       cycles;
  int unsigned       cycle_limit;
  logic [31:0]       lfsr;
  int unsigned       prop_fails [NUM_CH];

  pmp_top dut_i (
    .clk_i       (clk),
    .arst_n_i    (arst_n),
    .cfg_req_i   (cfg_req),
    .cfg_wr_i    (cfg_wr),
    .cfg_ack_o   (cfg_ack),
    .chan_req_i  (chan_req),
    .chan_i      (chan),
    .chan_ack_o  (chan_ack),
    .chan_err_o  (chan_err),
    .fault_clr_i (fault_clr),
    .fault_vld_o (fault_vld),
    .fault_o     (fault)
  );

  // Assertion failures from the bound checker properties
  for (genvar c = 0; c < NUM_CH; c++) begin : g_props
    assign prop_fails[c] = dut_i.g_chan[c].u_chan_check.u_props.fail_cnt;
  end

  always #50 clk = ~clk;

  // Run limit of 40 cycles per case plus 100
  always @(posedge clk) begin
    cycles++;
    if (cycle_limit != 0 && cycles >= cycle_limit) begin
      $display("timeout: the test did not finish within %0d clock cycles", cycles);
      $display("sim failed");
      $finish;
    end
  end

  // --------------------
  // Helpers
  // --------------------

  // Taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // Two LFSR bits give 0 to 3 idle cycles
  task automatic idle_gap();
    int unsigned n;
    n = 0;
    repeat (2) begin
      lfsr = lfsr_next(lfsr);
      n = (n << 1) | lfsr[0];
    end
    repeat (n) @(negedge clk);
  endtask

  task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic load_cases();
    int               fd;
    int               r;
    int unsigned      nf;
    byte              k;
    logic [31:0]      val;
    logic [8*128-1:0] skip;
    num_cases = 0;
    fd = $fopen("sim/pmp_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open sim/pmp_cases.txt, so no cases were run");
      errors++;
      return;
    end
    while (num_cases < MAX_CASES) begin
      r = $fscanf(fd, " %c", k);
      if (r != 1) break;
      case (k)
        "W":      nf = 3;
        "C", "F": nf = 4;
        "P":      nf = 9;
        default:  nf = 0;
      endcase
      if (nf == 0) begin
        // Comment line or a kind the testbench does not know
        if (k != "#") begin
          $display("cases file has a line of unknown kind %c", k);
          errors++;
        end
        r = $fgets(skip, fd);
      end else begin
        kind[num_cases] = k;
        for (int i = 0; i < nf; i++) begin
          r = $fscanf(fd, " %h", val);
          fld[num_cases][i] = val;
        end
        num_cases++;
      end
    end
    $fclose(fd);
  endtask

  // --------------------
  // Bus tasks
  // --------------------

  task automatic cfg_write(input logic [3:0] idx, input logic sel, input pmp_addr_t data);
    idle_gap();
    cfg_wr.index    = idx;
    cfg_wr.sel_addr = sel;
    cfg_wr.data     = data;
    cfg_req         = 1'b1;
    @(negedge clk);
    while (!cfg_ack) @(negedge clk);
    cfg_req = 1'b0;
    @(negedge clk);
    while (cfg_ack) @(negedge clk);
  endtask

  task automatic run_check(input int unsigned ch, input pmp_addr_t addr, input pmp_acc_t acc,
                           input logic exp);
    idle_gap();
    chan[ch].addr = addr;
    chan[ch].acc  = acc;
    chan_req[ch]  = 1'b1;
    @(negedge clk);
    while (!chan_ack[ch]) @(negedge clk);
    check_value(chan_err[ch], exp, $sformatf("channel %0d error at %0h", ch, addr));
    // Master keeps req up a few more cycles so ack and error must stay put
    idle_gap();
    chan_req[ch] = 1'b0;
    @(negedge clk);
    while (chan_ack[ch]) @(negedge clk);
  endtask

  // All channels raise req on the same edge
  task automatic run_parallel(input int unsigned n);
    idle_gap();
    for (int c = 0; c < NUM_CH; c++) begin
      chan[c].addr = fld[n][3*c];
      chan[c].acc  = fld[n][3*c+1][1:0];
    end
    chan_req = '1;
    @(negedge clk);
    while (!(&chan_ack)) @(negedge clk);
    for (int c = 0; c < NUM_CH; c++) begin
      check_value(chan_err[c], fld[n][3*c+2][0], $sformatf("parallel channel %0d error", c));
    end
    // Back-pressure on all channels at once
    idle_gap();
    chan_req = '0;
    @(negedge clk);
    while (|chan_ack) @(negedge clk);
  endtask

  // Compare the log record and clear it
  task automatic fault_check(input logic vld, input logic [3:0] ch, input pmp_addr_t addr,
                             input pmp_acc_t acc);
    check_value(fault_vld, vld, "fault log valid");
    if (vld) begin
      check_value(fault.chan, ch, "fault channel");
      check_value(fault.addr, addr, "fault address");
      check_value(fault.acc, acc, "fault access type");
    end
    fault_clr = 1'b1;
    @(negedge clk);
    fault_clr = 1'b0;
    check_value(fault_vld, 1'b0, "fault log valid after clear");
  endtask

  task automatic run_case(input int unsigned n);
    case (kind[n])
      "W":     cfg_write(fld[n][0][3:0], fld[n][1][0], fld[n][2]);
      "C":     run_check(fld[n][0], fld[n][1], fld[n][2][1:0], fld[n][3][0]);
      "F":     fault_check(fld[n][0][0], fld[n][1][3:0], fld[n][2], fld[n][3][1:0]);
      default: run_parallel(n);
    endcase
  endtask

  // --------------------
  // Main sequence
  // --------------------

  initial begin
    clk         = 1'b0;
    arst_n      = 1'b0;
    cfg_req     = 1'b0;
    cfg_wr      = '0;
    chan_req    = '0;
    fault_clr   = 1'b0;
    errors      = 0;
    cycles      = 0;
    cycle_limit = 0;
    lfsr        = 32'h426e;
    for (int c = 0; c < NUM_CH; c++) begin
      chan[c] = '0;
    end
    load_cases();
    cycle_limit = 40 * num_cases + 100;
    repeat (3) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    check_value(cfg_ack, 1'b0, "config ack after reset");
    check_value(chan_ack, '0, "channel acks after reset");
    check_value(fault_vld, 1'b0, "fault log valid after reset");
    for (int unsigned n = 0; n < num_cases; n++) begin
      run_case(n);
    end
    @(negedge clk);
    for (int c = 0; c < NUM_CH; c++) begin
      errors += prop_fails[c];
    end
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== sim/pmp_cases.txt ====
# W index sel_addr data | C chan addr acc err | F vld chan addr acc, then clear
# P addr acc err for channels 0 1 2 at once | all fields hex
C 0 00001000 0 0
C 1 fffffffc 1 0
C 2 00000040 2 0
F 0 0 00000000 0
W 0 1 00000040
W 0 0 00000031
C 0 00000100 0 0
C 0 00000102 1 1
C 1 00000104 1 0
C 2 00000100 2 1
F 1 0 00000102 1
W 1 1 000009ff
W 1 0 0000003b
C 0 00002ffc 1 0
C 1 00002abc 2 1
C 2 00003000 2 0
F 1 1 00002abc 2
W 2 1 00002000
W 2 0 0000002c
C 0 00004000 0 1
C 1 00004000 2 0
C 2 00008000 0 0
C 2 000027fc 0 0
F 1 0 00004000 0
W 0 0 00000008
W 3 1 000001ff
W 3 0 00000038
P 00000080 1 0 00000100 0 1 00004000 2 0
F 1 1 00000100 0
P 00007ffc 0 1 00004000 1 1 00002000 0 0
F 1 0 00007ffc 0
W 2 0 0000002d
C 2 00004000 0 0
F 0 0 00000000 0

// ==== sources.f ====
source/pmp_pkg.sv
source/pmp_cfg_regs.sv
source/pmp_region_decode.sv
source/pmp_chan_check.sv
source/pmp_fault_log.sv
source/pmp_top.sv
sim/pmp_props.sv
sim/pmp_tb.sv

// ==== Bender.yml ====
package:
  name: pmp

sources:
  - source/pmp_pkg.sv
  - source/pmp_cfg_regs.sv
  - source/pmp_region_decode.sv
  - source/pmp_chan_check.sv
  - source/pmp_fault_log.sv
  - source/pmp_top.sv
  - target: simulation
    files:
      - sim/pmp_props.sv
      - sim/pmp_tb.sv
